/* src/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 64
`define MEM_STRB_W 8

// on-chip array, in 64-bit words
`define MEM_DEPTH 256

// response codes
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

// fixed attributes, single beat only
`define AXI_BURST_INCR   2'b01
`define AXI_PROT_DATA    3'b000   // unprivileged, secure, data access
`define AXI_CACHE_NORMAL 4'b0010  // normal non-cacheable non-bufferable

`endif

/* src/mem_pkg.sv */
package mem_pkg;

    // request opcode, arbiter to bridge
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // bridge write side
    typedef enum logic [1:0] {
        WR_IDLE = 2'b00,
        WR_AW   = 2'b01,
        WR_W    = 2'b11,
        WR_B    = 2'b10
    } wr_state_e;

    // bridge read side
    typedef enum logic [1:0] {
        RD_IDLE = 2'b00,
        RD_AR   = 2'b01,
        RD_R    = 2'b11
    } rd_state_e;

    // sram slave
    typedef enum logic [1:0] {
        SLV_IDLE = 2'b00,
        SLV_W    = 2'b01,
        SLV_B    = 2'b11,
        SLV_R    = 2'b10
    } slv_state_e;

endpackage

/* src/mem_req_arbiter.sv */
`include "mem_consts.svh"

module mem_req_arbiter (
    input  logic                   clock,
    input  logic                   reset,

    input  logic                   fetch_valid_i,
    input  logic [`MEM_ADDR_W-1:0] fetch_addr_i,
    output logic                   fetch_ready_o,
    output logic                   fetch_rvalid_o,
    output logic [`MEM_DATA_W-1:0] fetch_rdata_o,
    output logic                   fetch_err_o,

    input  logic                   data_valid_i,
    input  logic                   data_write_i,
    input  logic [`MEM_ADDR_W-1:0] data_addr_i,
    input  logic [`MEM_DATA_W-1:0] data_wdata_i,
    input  logic [`MEM_STRB_W-1:0] data_wstrb_i,
    output logic                   data_ready_o,
    output logic                   data_rvalid_o,
    output logic [`MEM_DATA_W-1:0] data_rdata_o,
    output logic                   data_err_o,

    output logic                   req_valid_o,
    output mem_pkg::mem_op_e       req_op_o,
    output logic [`MEM_ADDR_W-1:0] req_addr_o,
    output logic [`MEM_DATA_W-1:0] req_wdata_o,
    output logic [`MEM_STRB_W-1:0] req_wstrb_o,
    input  logic                   req_ready_i,
    input  logic                   resp_valid_i,
    input  logic [`MEM_DATA_W-1:0] resp_rdata_i,
    input  logic                   resp_err_i
);

    logic last_fetch_q;  // fetch was served last
    logic busy_q;        // request in flight
    logic owner_data_q;  // in-flight request came from data port
    logic grant_data;
    logic grant_fetch;
    logic accept;

    // data wins when alone or on a tie if fetch went last
    assign grant_data  = data_valid_i & (~fetch_valid_i | last_fetch_q);
    assign grant_fetch = fetch_valid_i & ~grant_data;

    // nothing is offered or taken while reset is held
    assign req_valid_o = reset & ~busy_q & (fetch_valid_i | data_valid_i);
    assign req_op_o    = (grant_data && data_write_i) ? mem_pkg::OP_WRITE : mem_pkg::OP_READ;
    assign req_addr_o  = grant_data ? data_addr_i : fetch_addr_i;
    assign req_wdata_o = grant_data ? data_wdata_i : '0;  // fetch never writes
    assign req_wstrb_o = grant_data ? data_wstrb_i : '0;

    assign accept = req_valid_o & req_ready_i;

    assign fetch_ready_o = reset & ~busy_q & grant_fetch & req_ready_i;
    assign data_ready_o  = reset & ~busy_q & grant_data & req_ready_i;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            last_fetch_q <= 1'b1;  // so data takes the first tie
            busy_q       <= 1'b0;
            owner_data_q <= 1'b0;
        end else if (accept) begin
            last_fetch_q <= ~grant_data;
            busy_q       <= 1'b1;
            owner_data_q <= grant_data;
        end else if (resp_valid_i) begin
            busy_q <= 1'b0;
        end
    end

    // response steering
    assign fetch_rvalid_o = resp_valid_i & ~owner_data_q;
    assign data_rvalid_o  = resp_valid_i & owner_data_q;
    assign fetch_rdata_o  = resp_rdata_i;
    assign data_rdata_o   = resp_rdata_i;
    assign fetch_err_o    = resp_err_i;
    assign data_err_o     = resp_err_i;

endmodule

/* src/axi_master_bridge.sv */
`include "mem_consts.svh"

module axi_master_bridge (
    input  logic                   clock,
    input  logic                   reset,

    input  logic                   req_valid_i,
    input  mem_pkg::mem_op_e       req_op_i,
    input  logic [`MEM_ADDR_W-1:0] req_addr_i,
    input  logic [`MEM_DATA_W-1:0] req_wdata_i,
    input  logic [`MEM_STRB_W-1:0] req_wstrb_i,
    output logic                   req_ready_o,
    output logic                   resp_valid_o,
    output logic [`MEM_DATA_W-1:0] resp_rdata_o,
    output logic                   resp_err_o,

    output logic                   aw_valid_o,
    output logic [`MEM_ADDR_W-1:0] aw_addr_o,
    output logic [2:0]             aw_size_o,
    output logic [1:0]             aw_burst_o,
    output logic [2:0]             aw_prot_o,
    output logic [3:0]             aw_cache_o,
    input  logic                   aw_ready_i,

    output logic                   w_valid_o,
    output logic [`MEM_DATA_W-1:0] w_data_o,
    output logic [`MEM_STRB_W-1:0] w_strb_o,
    output logic                   w_last_o,
    input  logic                   w_ready_i,

    input  logic                   b_valid_i,
    input  logic [1:0]             b_resp_i,
    output logic                   b_ready_o,

    output logic                   ar_valid_o,
    output logic [`MEM_ADDR_W-1:0] ar_addr_o,
    output logic [2:0]             ar_size_o,
    output logic [1:0]             ar_burst_o,
    output logic [2:0]             ar_prot_o,
    output logic [3:0]             ar_cache_o,
    input  logic                   ar_ready_i,

    input  logic                   r_valid_i,
    input  logic [`MEM_DATA_W-1:0] r_data_i,
    input  logic [1:0]             r_resp_i,
    output logic                   r_ready_o
);

    mem_pkg::wr_state_e     wr_state_q;
    mem_pkg::wr_state_e     wr_state_d;
    mem_pkg::rd_state_e     rd_state_q;
    mem_pkg::rd_state_e     rd_state_d;
    logic                   accept;
    logic [`MEM_ADDR_W-1:0] addr_q;
    logic [`MEM_DATA_W-1:0] wdata_q;
    logic [`MEM_STRB_W-1:0] wstrb_q;

    assign req_ready_o = (wr_state_q == mem_pkg::WR_IDLE) && (rd_state_q == mem_pkg::RD_IDLE);
    assign accept      = req_valid_i & req_ready_o;

    // request held here for the whole transaction
    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
            wstrb_q <= req_wstrb_i;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_state_q <= mem_pkg::WR_IDLE;
            rd_state_q <= mem_pkg::RD_IDLE;
        end else begin
            wr_state_q <= wr_state_d;
            rd_state_q <= rd_state_d;
        end
    end

    // write side: aw, then w, then b
    always_comb begin
        wr_state_d = wr_state_q;
        case (wr_state_q)
            mem_pkg::WR_IDLE: if (accept && req_op_i == mem_pkg::OP_WRITE) wr_state_d = mem_pkg::WR_AW;
            mem_pkg::WR_AW:   if (aw_ready_i) wr_state_d = mem_pkg::WR_W;
            mem_pkg::WR_W:    if (w_ready_i) wr_state_d = mem_pkg::WR_B;
            mem_pkg::WR_B:    if (b_valid_i) wr_state_d = mem_pkg::WR_IDLE;
            default:          wr_state_d = mem_pkg::WR_IDLE;
        endcase
    end

    // read side: ar, then r
    always_comb begin
        rd_state_d = rd_state_q;
        case (rd_state_q)
            mem_pkg::RD_IDLE: if (accept && req_op_i == mem_pkg::OP_READ) rd_state_d = mem_pkg::RD_AR;
            mem_pkg::RD_AR:   if (ar_ready_i) rd_state_d = mem_pkg::RD_R;
            mem_pkg::RD_R:    if (r_valid_i) rd_state_d = mem_pkg::RD_IDLE;
            default:          rd_state_d = mem_pkg::RD_IDLE;
        endcase
    end

    // one-cycle response pulse
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= (b_valid_i && b_ready_o) || (r_valid_i && r_ready_o);
        end
    end

    always_ff @(posedge clock) begin
        if (b_valid_i && b_ready_o) begin
            resp_rdata_o <= '0;  // writes return zero
            resp_err_o   <= (b_resp_i != `AXI_RESP_OKAY);
        end else if (r_valid_i && r_ready_o) begin
            resp_rdata_o <= r_data_i;
            resp_err_o   <= (r_resp_i != `AXI_RESP_OKAY);
        end
    end

    assign aw_valid_o = (wr_state_q == mem_pkg::WR_AW);
    assign aw_addr_o  = addr_q;
    assign aw_size_o  = 3'($clog2(`MEM_STRB_W));  // full bus width
    assign aw_burst_o = `AXI_BURST_INCR;
    assign aw_prot_o  = `AXI_PROT_DATA;
    assign aw_cache_o = `AXI_CACHE_NORMAL;

    assign w_valid_o = (wr_state_q == mem_pkg::WR_W);
    assign w_data_o  = wdata_q;
    assign w_strb_o  = wstrb_q;
    assign w_last_o  = w_valid_o;  // single beat
    assign b_ready_o = (wr_state_q == mem_pkg::WR_B);

    assign ar_valid_o = (rd_state_q == mem_pkg::RD_AR);
    assign ar_addr_o  = addr_q;
    assign ar_size_o  = 3'($clog2(`MEM_STRB_W));
    assign ar_burst_o = `AXI_BURST_INCR;
    assign ar_prot_o  = `AXI_PROT_DATA;
    assign ar_cache_o = `AXI_CACHE_NORMAL;
    assign r_ready_o  = (rd_state_q == mem_pkg::RD_R);

endmodule

/* src/axi_sram_slave.sv */
`include "mem_consts.svh"

module axi_sram_slave (
    input  logic                   clock,
    input  logic                   reset,

    input  logic                   aw_valid_i,
    input  logic [`MEM_ADDR_W-1:0] aw_addr_i,
    output logic                   aw_ready_o,

    input  logic                   w_valid_i,
    input  logic [`MEM_DATA_W-1:0] w_data_i,
    input  logic [`MEM_STRB_W-1:0] w_strb_i,
    output logic                   w_ready_o,

    output logic                   b_valid_o,
    output logic [1:0]             b_resp_o,
    input  logic                   b_ready_i,

    input  logic                   ar_valid_i,
    input  logic [`MEM_ADDR_W-1:0] ar_addr_i,
    output logic                   ar_ready_o,

    output logic                   r_valid_o,
    output logic [`MEM_DATA_W-1:0] r_data_o,
    output logic [1:0]             r_resp_o,
    input  logic                   r_ready_i
);

    logic [`MEM_DATA_W-1:0] mem [`MEM_DEPTH];
    mem_pkg::slv_state_e    state_q;
    logic [`MEM_ADDR_W-1:0] waddr_q;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   ar_hs;

    // byte address to word, checked against the array depth
    function automatic logic in_range(input logic [`MEM_ADDR_W-1:0] addr);
        return (addr >> $clog2(`MEM_STRB_W)) < `MEM_DEPTH;
    endfunction

    function automatic logic [$clog2(`MEM_DEPTH)-1:0] word_idx(
        input logic [`MEM_ADDR_W-1:0] addr
    );
        return addr[$clog2(`MEM_STRB_W) +: $clog2(`MEM_DEPTH)];
    endfunction

    assign aw_ready_o = (state_q == mem_pkg::SLV_IDLE);
    assign ar_ready_o = (state_q == mem_pkg::SLV_IDLE) && !aw_valid_i;  // write goes first
    assign w_ready_o  = (state_q == mem_pkg::SLV_W);
    assign b_valid_o  = (state_q == mem_pkg::SLV_B);
    assign r_valid_o  = (state_q == mem_pkg::SLV_R);

    assign aw_hs = aw_valid_i & aw_ready_o;
    assign w_hs  = w_valid_i & w_ready_o;
    assign ar_hs = ar_valid_i & ar_ready_o;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= mem_pkg::SLV_IDLE;
        end else begin
            case (state_q)
                mem_pkg::SLV_IDLE: begin
                    if (aw_hs)      state_q <= mem_pkg::SLV_W;
                    else if (ar_hs) state_q <= mem_pkg::SLV_R;
                end
                mem_pkg::SLV_W: if (w_hs) state_q <= mem_pkg::SLV_B;
                mem_pkg::SLV_B: if (b_ready_i) state_q <= mem_pkg::SLV_IDLE;
                mem_pkg::SLV_R: if (r_ready_i) state_q <= mem_pkg::SLV_IDLE;
                default:        state_q <= mem_pkg::SLV_IDLE;
            endcase
        end
    end

    // array, write address and response payload
    always_ff @(posedge clock) begin
        if (aw_hs) begin
            waddr_q <= aw_addr_i;
        end
        if (w_hs) begin
            if (in_range(waddr_q)) begin
                for (int i = 0; i < `MEM_STRB_W; i++) begin
                    if (w_strb_i[i]) mem[word_idx(waddr_q)][8*i +: 8] <= w_data_i[8*i +: 8];
                end
                b_resp_o <= `AXI_RESP_OKAY;
            end else begin
                b_resp_o <= `AXI_RESP_SLVERR;  // out of range, array untouched
            end
        end
        if (ar_hs) begin
            if (in_range(ar_addr_i)) begin
                r_data_o <= mem[word_idx(ar_addr_i)];
                r_resp_o <= `AXI_RESP_OKAY;
            end else begin
                r_data_o <= '0;
                r_resp_o <= `AXI_RESP_SLVERR;
            end
        end
    end

endmodule

/* src/mem_subsys_top.sv */
`include "mem_consts.svh"

module mem_subsys_top (
    input  logic                   clock,
    input  logic                   reset,

    input  logic                   fetch_valid_i,
    input  logic [`MEM_ADDR_W-1:0] fetch_addr_i,
    output logic                   fetch_ready_o,
    output logic                   fetch_rvalid_o,
    output logic [`MEM_DATA_W-1:0] fetch_rdata_o,
    output logic                   fetch_err_o,

    input  logic                   data_valid_i,
    input  logic                   data_write_i,
    input  logic [`MEM_ADDR_W-1:0] data_addr_i,
    input  logic [`MEM_DATA_W-1:0] data_wdata_i,
    input  logic [`MEM_STRB_W-1:0] data_wstrb_i,
    output logic                   data_ready_o,
    output logic                   data_rvalid_o,
    output logic [`MEM_DATA_W-1:0] data_rdata_o,
    output logic                   data_err_o
);

    // arbiter to bridge
    logic                   req_valid;
    mem_pkg::mem_op_e       req_op;
    logic [`MEM_ADDR_W-1:0] req_addr;
    logic [`MEM_DATA_W-1:0] req_wdata;
    logic [`MEM_STRB_W-1:0] req_wstrb;
    logic                   req_ready;
    logic                   resp_valid;
    logic [`MEM_DATA_W-1:0] resp_rdata;
    logic                   resp_err;

    // bridge to slave
    logic                   aw_valid;
    logic                   aw_ready;
    logic [`MEM_ADDR_W-1:0] aw_addr;
    logic                   w_valid;
    logic                   w_ready;
    logic [`MEM_DATA_W-1:0] w_data;
    logic [`MEM_STRB_W-1:0] w_strb;
    logic                   b_valid;
    logic                   b_ready;
    logic [1:0]             b_resp;
    logic                   ar_valid;
    logic                   ar_ready;
    logic [`MEM_ADDR_W-1:0] ar_addr;
    logic                   r_valid;
    logic                   r_ready;
    logic [`MEM_DATA_W-1:0] r_data;
    logic [1:0]             r_resp;

    mem_req_arbiter u_arbiter (
        .clock          (clock),
        .reset          (reset),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_ready_o  (fetch_ready_o),
        .fetch_rvalid_o (fetch_rvalid_o),
        .fetch_rdata_o  (fetch_rdata_o),
        .fetch_err_o    (fetch_err_o),
        .data_valid_i   (data_valid_i),
        .data_write_i   (data_write_i),
        .data_addr_i    (data_addr_i),
        .data_wdata_i   (data_wdata_i),
        .data_wstrb_i   (data_wstrb_i),
        .data_ready_o   (data_ready_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .data_err_o     (data_err_o),
        .req_valid_o    (req_valid),
        .req_op_o       (req_op),
        .req_addr_o     (req_addr),
        .req_wdata_o    (req_wdata),
        .req_wstrb_o    (req_wstrb),
        .req_ready_i    (req_ready),
        .resp_valid_i   (resp_valid),
        .resp_rdata_i   (resp_rdata),
        .resp_err_i     (resp_err)
    );

    // attribute fields and w_last are not used by this slave
    axi_master_bridge u_bridge (
        .clock        (clock),
        .reset        (reset),
        .req_valid_i  (req_valid),
        .req_op_i     (req_op),
        .req_addr_i   (req_addr),
        .req_wdata_i  (req_wdata),
        .req_wstrb_i  (req_wstrb),
        .req_ready_o  (req_ready),
        .resp_valid_o (resp_valid),
        .resp_rdata_o (resp_rdata),
        .resp_err_o   (resp_err),
        .aw_valid_o   (aw_valid),
        .aw_addr_o    (aw_addr),
        .aw_size_o    (),
        .aw_burst_o   (),
        .aw_prot_o    (),
        .aw_cache_o   (),
        .aw_ready_i   (aw_ready),
        .w_valid_o    (w_valid),
        .w_data_o     (w_data),
        .w_strb_o     (w_strb),
        .w_last_o     (),
        .w_ready_i    (w_ready),
        .b_valid_i    (b_valid),
        .b_resp_i     (b_resp),
        .b_ready_o    (b_ready),
        .ar_valid_o   (ar_valid),
        .ar_addr_o    (ar_addr),
        .ar_size_o    (),
        .ar_burst_o   (),
        .ar_prot_o    (),
        .ar_cache_o   (),
        .ar_ready_i   (ar_ready),
        .r_valid_i    (r_valid),
        .r_data_i     (r_data),
        .r_resp_i     (r_resp),
        .r_ready_o    (r_ready)
    );

    axi_sram_slave u_sram (
        .clock      (clock),
        .reset      (reset),
        .aw_valid_i (aw_valid),
        .aw_addr_i  (aw_addr),
        .aw_ready_o (aw_ready),
        .w_valid_i  (w_valid),
        .w_data_i   (w_data),
        .w_strb_i   (w_strb),
        .w_ready_o  (w_ready),
        .b_valid_o  (b_valid),
        .b_resp_o   (b_resp),
        .b_ready_i  (b_ready),
        .ar_valid_i (ar_valid),
        .ar_addr_i  (ar_addr),
        .ar_ready_o (ar_ready),
        .r_valid_o  (r_valid),
        .r_data_o   (r_data),
        .r_resp_o   (r_resp),
        .r_ready_i  (r_ready)
    );

endmodule

/* dv/mem_subsys_tb.sv */
`include "mem_consts.svh"

module mem_subsys_tb;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS  = 6;
    localparam int BYTE_SH    = $clog2(`MEM_STRB_W);
    localparam int WORD_W     = $clog2(`MEM_DEPTH);

    logic                   clock;
    logic                   reset;
    logic                   fetch_valid_i;
    logic [`MEM_ADDR_W-1:0] fetch_addr_i;
    logic                   fetch_ready_o;
    logic                   fetch_rvalid_o;
    logic [`MEM_DATA_W-1:0] fetch_rdata_o;
    logic                   fetch_err_o;
    logic                   data_valid_i;
    logic                   data_write_i;
    logic [`MEM_ADDR_W-1:0] data_addr_i;
    logic [`MEM_DATA_W-1:0] data_wdata_i;
    logic [`MEM_STRB_W-1:0] data_wstrb_i;
    logic                   data_ready_o;
    logic                   data_rvalid_o;
    logic [`MEM_DATA_W-1:0] data_rdata_o;
    logic                   data_err_o;

    logic [`MEM_DATA_W-1:0] ref_mem [`MEM_DEPTH];  // reference copy of the array
    logic [31:0]            lcg_state;
    int                     errors;
    int                     errors_mark;
    int                     tests_done;
    logic                   reset_d;       // low during reset and the cycle after
    logic                   f_pend;        // fetch request accepted and no rvalid yet
    logic                   d_pend;
    logic                   last_fetch_m;  // fetch served last under the arbitration rule
    logic [`MEM_DATA_W-1:0] exp_f_rdata;
    logic [`MEM_DATA_W-1:0] exp_d_rdata;
    logic                   exp_f_err;
    logic                   exp_d_err;

    mem_subsys_top DUT (
        .clock          (clock),
        .reset          (reset),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_ready_o  (fetch_ready_o),
        .fetch_rvalid_o (fetch_rvalid_o),
        .fetch_rdata_o  (fetch_rdata_o),
        .fetch_err_o    (fetch_err_o),
        .data_valid_i   (data_valid_i),
        .data_write_i   (data_write_i),
        .data_addr_i    (data_addr_i),
        .data_wdata_i   (data_wdata_i),
        .data_wstrb_i   (data_wstrb_i),
        .data_ready_o   (data_ready_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .data_err_o     (data_err_o)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // word index is the byte address divided by 8
    function automatic logic addr_in_range(input logic [`MEM_ADDR_W-1:0] addr);
        return (addr / `MEM_STRB_W) < `MEM_DEPTH;
    endfunction

    function automatic logic [`MEM_DATA_W-1:0] model_read(input logic [`MEM_ADDR_W-1:0] addr);
        if (!addr_in_range(addr)) return '0;
        return ref_mem[WORD_W'(addr >> BYTE_SH)];
    endfunction

    function automatic void model_write(
        input logic [`MEM_ADDR_W-1:0] addr,
        input logic [`MEM_DATA_W-1:0] wdata,
        input logic [`MEM_STRB_W-1:0] wstrb
    );
        logic [`MEM_DATA_W-1:0] word;
        if (addr_in_range(addr)) begin
            word = ref_mem[WORD_W'(addr >> BYTE_SH)];
            for (int i = 0; i < `MEM_STRB_W; i++) begin
                if (wstrb[i]) word[8*i +: 8] = wdata[8*i +: 8];  // byte merge
            end
            ref_mem[WORD_W'(addr >> BYTE_SH)] = word;
        end
    endfunction

    task automatic value_error(input string sig, input logic [63:0] exp, input logic [63:0] act);
        $display("ERROR t=%0t %s expected %h got %h", $time, sig, exp, act);
        errors++;
    endtask

    task automatic rule_error(input string what);
        $display("ERROR t=%0t %s", $time, what);
        errors++;
    endtask

    task automatic end_test(input string name);
        @(posedge clock);  // lets checks on the last pulse finish first
        tests_done++;
        $display("test %0d %-13s done, %0d errors", tests_done, name, errors - errors_mark);
        errors_mark = errors;
    endtask

    task automatic fetch_read(input logic [`MEM_ADDR_W-1:0] addr);
        @(posedge clock);
        #2;
        fetch_valid_i = 1'b1;
        fetch_addr_i  = addr;
        do @(negedge clock); while (!fetch_ready_o);
        // model is applied in acceptance order
        exp_f_rdata = model_read(addr);
        exp_f_err   = !addr_in_range(addr);
        @(posedge clock);
        #2;
        fetch_valid_i = 1'b0;
        do @(negedge clock); while (!fetch_rvalid_o);
    endtask

    task automatic data_access(
        input logic                   write,
        input logic [`MEM_ADDR_W-1:0] addr,
        input logic [`MEM_DATA_W-1:0] wdata,
        input logic [`MEM_STRB_W-1:0] wstrb
    );
        @(posedge clock);
        #2;
        data_valid_i = 1'b1;
        data_write_i = write;
        data_addr_i  = addr;
        data_wdata_i = wdata;
        data_wstrb_i = wstrb;
        do @(negedge clock); while (!data_ready_o);
        exp_d_err = !addr_in_range(addr);
        if (write) begin
            model_write(addr, wdata, wstrb);
            exp_d_rdata = '0;  // write response carries zero
        end else begin
            exp_d_rdata = model_read(addr);
        end
        @(posedge clock);
        #2;
        data_valid_i = 1'b0;
        do @(negedge clock); while (!data_rvalid_o);
    endtask

    // request bookkeeping sampled like a flop at the handshake edge
    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            reset_d      <= 1'b0;
            f_pend       <= 1'b0;
            d_pend       <= 1'b0;
            last_fetch_m <= 1'b1;
        end else begin
            reset_d <= 1'b1;
            if (fetch_valid_i && fetch_ready_o) begin
                f_pend       <= 1'b1;
                last_fetch_m <= 1'b1;
            end else if (fetch_rvalid_o) begin
                f_pend <= 1'b0;
            end
            if (data_valid_i && data_ready_o) begin
                d_pend       <= 1'b1;
                last_fetch_m <= 1'b0;
            end else if (data_rvalid_o) begin
                d_pend <= 1'b0;
            end
        end
    end

    // all checks sample at the falling edge where everything is settled
    rst_fetch_rvalid: assert property (@(negedge clock) !reset_d |-> !fetch_rvalid_o)
        else value_error("fetch_rvalid_o", 64'(0), 64'(fetch_rvalid_o));
    rst_data_rvalid: assert property (@(negedge clock) !reset_d |-> !data_rvalid_o)
        else value_error("data_rvalid_o", 64'(0), 64'(data_rvalid_o));
    rst_fetch_ready: assert property (@(negedge clock) !reset |-> !fetch_ready_o)
        else value_error("fetch_ready_o", 64'(0), 64'(fetch_ready_o));
    rst_data_ready: assert property (@(negedge clock) !reset |-> !data_ready_o)
        else value_error("data_ready_o", 64'(0), 64'(data_ready_o));

    fetch_owner: assert property (@(negedge clock) fetch_rvalid_o |-> f_pend)
        else rule_error("fetch_rvalid_o pulsed with no fetch request outstanding");
    data_owner: assert property (@(negedge clock) data_rvalid_o |-> d_pend)
        else rule_error("data_rvalid_o pulsed with no data request outstanding");

    fetch_rdata_chk: assert property (
        @(negedge clock) fetch_rvalid_o |-> fetch_rdata_o == exp_f_rdata
    ) else value_error("fetch_rdata_o", exp_f_rdata, fetch_rdata_o);
    data_rdata_chk: assert property (
        @(negedge clock) data_rvalid_o |-> data_rdata_o == exp_d_rdata
    ) else value_error("data_rdata_o", exp_d_rdata, data_rdata_o);
    fetch_err_chk: assert property (@(negedge clock) fetch_rvalid_o |-> fetch_err_o == exp_f_err)
        else value_error("fetch_err_o", 64'(exp_f_err), 64'(fetch_err_o));
    data_err_chk: assert property (@(negedge clock) data_rvalid_o |-> data_err_o == exp_d_err)
        else value_error("data_err_o", 64'(exp_d_err), 64'(data_err_o));

    busy_fetch_ready: assert property (@(negedge clock) (f_pend || d_pend) |-> !fetch_ready_o)
        else rule_error("fetch_ready_o high while a request is outstanding");
    busy_data_ready: assert property (@(negedge clock) (f_pend || d_pend) |-> !data_ready_o)
        else rule_error("data_ready_o high while a request is outstanding");

    tie_fetch: assert property (
        @(negedge clock) (fetch_valid_i && data_valid_i && fetch_ready_o) |-> !last_fetch_m
    ) else rule_error("fetch granted on a tie although fetch was served last");
    tie_data: assert property (
        @(negedge clock) (fetch_valid_i && data_valid_i && data_ready_o) |-> last_fetch_m
    ) else rule_error("data granted on a tie although data was served last");

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", NUM_TESTS * 200);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_ADDR_W-1:0] addr2;
        logic [31:0]            r;
        logic [`MEM_DATA_W-1:0] wdata;
        logic [`MEM_STRB_W-1:0] wstrb;
        clock         = 1'b0;
        reset         = 1'b0;
        fetch_valid_i = 1'b1;  // both ports request while reset is held
        fetch_addr_i  = '0;
        data_valid_i  = 1'b1;
        data_write_i  = 1'b0;
        data_addr_i   = '0;
        data_wdata_i  = '0;
        data_wstrb_i  = '0;
        lcg_state     = 32'h3e9af96c;
        errors        = 0;
        errors_mark   = 0;
        tests_done    = 0;
        exp_f_rdata   = '0;
        exp_d_rdata   = '0;
        exp_f_err     = 1'b0;
        exp_d_err     = 1'b0;

        repeat (10) @(posedge clock);
        #2;
        fetch_valid_i = 1'b0;
        data_valid_i  = 1'b0;
        reset         = 1'b1;
        repeat (2) @(negedge clock);
        end_test("reset");

        // first tie after reset goes to data, so fetch reads the new word
        wdata = {next_rand(), next_rand()};
        fork
            data_access(1'b1, 32'h28, wdata, 8'hff);
            fetch_read(32'h28);
        join
        end_test("arbitration");

        addr = 32'h100;
        data_access(1'b1, addr, {next_rand(), next_rand()}, 8'hff);
        data_access(1'b0, addr, '0, '0);
        end_test("round_trip");

        for (int w = 0; w < 8; w++) begin
            addr = 32'(w * `MEM_STRB_W) | (next_rand() & 32'd7);
            data_access(1'b1, addr, {next_rand(), next_rand()}, 8'hff);
            data_access(1'b1, addr, {next_rand(), next_rand()}, 8'(next_rand()));
            data_access(1'b0, addr, '0, '0);
            fetch_read(addr);
        end
        end_test("byte_strobes");

        addr = 32'((`MEM_DEPTH + 3) * `MEM_STRB_W);  // low index bits alias word 3
        data_access(1'b1, addr, {next_rand(), next_rand()}, 8'hff);
        data_access(1'b0, addr, '0, '0);
        data_access(1'b0, 32'hffff_fff8, '0, '0);
        data_access(1'b0, 32'(3 * `MEM_STRB_W), '0, '0);
        fetch_read(32'(3 * `MEM_STRB_W));
        end_test("out_of_range");

        for (int n = 0; n < 40; n++) begin
            r     = next_rand();
            addr  = ((next_rand() % 32'd8) << BYTE_SH) | (next_rand() & 32'd7);
            addr2 = (next_rand() % 32'd8) << BYTE_SH;
            wdata = {next_rand(), next_rand()};
            wstrb = 8'(next_rand());
            case (r[1:0])
                2'd0: fetch_read(addr);
                2'd1: data_access(1'b0, addr, '0, '0);
                2'd2: data_access(1'b1, addr, wdata, wstrb);
                default: begin
                    fork
                        data_access(1'b1, addr, wdata, wstrb);
                        fetch_read(addr2);
                    join
                end
            endcase
        end
        end_test("random_mix");

        repeat (2) @(posedge clock);
        $display("%0d tests run, %0d errors", tests_done, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+src
src/mem_pkg.sv
src/mem_req_arbiter.sv
src/axi_master_bridge.sv
src/axi_sram_slave.sv
src/mem_subsys_top.sv
dv/mem_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f sim.f --top-module mem_subsys_tb -Mdir obj_dir -o sim_bin \
    && ./obj_dir/sim_bin > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null
grep -q "PASS: all tests" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
